// ==== verilog/rdma_op_pkg.sv ====
package rdma_op_pkg;

  // RC wire opcodes seen by the network stack
  typedef enum logic [4:0] {
    WRITE_FIRST  = 5'd6,
    WRITE_MIDDLE = 5'd7,
    WRITE_LAST   = 5'd8,
    WRITE_ONLY   = 5'd10,
    READ_REQUEST = 5'd12,
    RPC_REQUEST  = 5'd24
  } rc_op_t;

  // largest payload carried by one write packet
  localparam int unsigned pmtu_bytes = 4096;

endpackage

// ==== verilog/req_fmt_pkg.sv ====
package req_fmt_pkg;

  // opcodes used by the application in parsed mode
  typedef enum logic [4:0] {
    APP_READ  = 5'd0,
    APP_WRITE = 5'd1,
    APP_RPC   = 5'd2
  } app_op_t;

  localparam int req_bits = 256;  // one request word

  // application request, fields listed MSB first
  typedef struct packed {
    logic [63:0] params;
    logic [31:0] len;
    logic [47:0] rvaddr;
    logic [47:0] lvaddr;
    logic [28:0] rsrvd;
    logic        raw;     // 1 = opcode and fields taken as they are
    logic        host;    // overwritten by the parser
    logic [3:0]  region;  // overwritten by the parser
    logic [23:0] qp;
    logic [4:0]  op;
  } app_req_t;

  // RC request towards the network stack
  typedef struct packed {
    logic [63:0] params;
    logic [31:0] len;
    logic [47:0] rvaddr;
    logic [47:0] lvaddr;
    logic [29:0] rsrvd;   // always zero
    logic        host;
    logic [3:0]  region;
    logic [23:0] qp;
    logic [4:0]  op;
  } rc_req_t;

endpackage

// ==== verilog/req_fifo.sv ====
`timescale 1ns/1ps

module req_fifo #(
  parameter int DEPTH = 16
) (
  input  logic                             aclk,
  input  logic                             aresetn,
  input  logic [req_fmt_pkg::req_bits-1:0] in_data,
  input  logic                             in_valid,
  output logic                             in_ready,
  output logic [req_fmt_pkg::req_bits-1:0] out_data,
  output logic                             out_valid,
  input  logic                             out_ready,
  output logic [31:0]                      used
);

  logic [req_fmt_pkg::req_bits-1:0] mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]         wr_ptr;
  logic [$clog2(DEPTH)-1:0]         rd_ptr;
  logic [31:0]                      count;
  logic                             push;
  logic                             pop;

  assign in_ready  = (count < DEPTH);
  assign out_valid = (count != 0);
  assign out_data  = mem[rd_ptr];  // head word valid once count is nonzero
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;
  assign used      = count;

  always_ff @(posedge aclk, negedge aresetn) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1;
        2'b01:   count <= count - 1;
        default: count <= count;  // idle or push and pop together
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  a_count_bound : assert property (@(posedge aclk) disable iff (!aresetn)
    count <= DEPTH)
    else $error("req_fifo count %0d above depth %0d", count, DEPTH);

endmodule

// ==== verilog/network_req_parser.sv ====
`timescale 1ns/1ps

module network_req_parser #(
  parameter int region_id   = 0,
  parameter int host_access = 0
) (
  input  logic                 aclk,
  input  logic                 aresetn,
  input  req_fmt_pkg::app_req_t req_in_data,
  input  logic                 req_in_valid,
  output logic                 req_in_ready,
  output req_fmt_pkg::rc_req_t  req_out_data,
  output logic                 req_out_valid,
  input  logic                 req_out_ready,
  output logic [31:0]          used
);

  typedef enum logic [2:0] {
    st_idle, st_parse_read, st_parse_write_init, st_parse_write,
    st_parse_rpc, st_send, st_send_write
  } state_t;

  state_t                state;
  state_t                state_nxt;
  req_fmt_pkg::app_req_t pre_data;   // head of input queue
  logic                  pre_valid;
  logic                  pre_ready;
  req_fmt_pkg::app_req_t req_q;      // request being worked on
  req_fmt_pkg::rc_req_t  pkt_q;      // packet waiting for the output queue
  logic                  pkt_valid;
  logic                  pkt_ready;
  logic [47:0]           lva;        // write carry between packets
  logic [47:0]           rva;
  logic [31:0]           len_rem;
  logic                  first_pkt;
  logic                  fits_pmtu;

  function automatic req_fmt_pkg::rc_req_t make_pkt(input logic [4:0] op,
                                                    input req_fmt_pkg::app_req_t src,
                                                    input logic [47:0] lvaddr,
                                                    input logic [47:0] rvaddr,
                                                    input logic [31:0] len);
    req_fmt_pkg::rc_req_t pkt;
    pkt.op     = op;
    pkt.qp     = src.qp;
    pkt.region = 4'(region_id);    // stamped per source
    pkt.host   = 1'(host_access);
    pkt.rsrvd  = '0;
    pkt.lvaddr = lvaddr;
    pkt.rvaddr = rvaddr;
    pkt.len    = len;
    pkt.params = src.params;
    return pkt;
  endfunction

  req_fifo #(.DEPTH(16)) inst_queue_in (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_data   (req_in_data),
    .in_valid  (req_in_valid),
    .in_ready  (req_in_ready),
    .out_data  (pre_data),
    .out_valid (pre_valid),
    .out_ready (pre_ready),
    .used      (used)
  );

  req_fifo #(.DEPTH(4)) inst_queue_out (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_data   (pkt_q),
    .in_valid  (pkt_valid),
    .in_ready  (pkt_ready),
    .out_data  (req_out_data),
    .out_valid (req_out_valid),
    .out_ready (req_out_ready),
    .used      ()
  );

  assign pre_ready = (state == st_idle);  // unknown opcodes get consumed here too
  assign pkt_valid = (state == st_send) || (state == st_send_write);
  assign first_pkt = (state == st_parse_write_init);
  assign fits_pmtu = (len_rem <= 32'(rdma_op_pkg::pmtu_bytes));

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle:
        if (pre_valid) begin
          if (pre_data.raw) begin
            state_nxt = st_send;
          end else begin
            case (pre_data.op)
              req_fmt_pkg::APP_READ:  state_nxt = st_parse_read;
              req_fmt_pkg::APP_WRITE: state_nxt = st_parse_write_init;
              req_fmt_pkg::APP_RPC:   state_nxt = st_parse_rpc;
              default:                state_nxt = st_idle;  // dropped
            endcase
          end
        end
      st_parse_read, st_parse_rpc:         state_nxt = st_send;
      st_parse_write_init, st_parse_write: state_nxt = st_send_write;
      st_send:
        if (pkt_ready) state_nxt = st_idle;
      st_send_write:
        if (pkt_ready) state_nxt = (len_rem != 0) ? st_parse_write : st_idle;
      default: state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge aclk, negedge aresetn) begin
    if (!aresetn) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge aclk) begin
    case (state)
      st_idle:
        if (pre_valid) begin
          req_q   <= pre_data;
          lva     <= pre_data.lvaddr;
          rva     <= pre_data.rvaddr;
          len_rem <= pre_data.len;
          if (pre_data.raw) begin  // raw goes straight to send
            pkt_q <= make_pkt(pre_data.op, pre_data, pre_data.lvaddr, pre_data.rvaddr,
                              pre_data.len);
          end
        end
      st_parse_read:
        pkt_q <= make_pkt(rdma_op_pkg::READ_REQUEST, req_q, req_q.lvaddr, req_q.rvaddr,
                          req_q.len);
      st_parse_rpc:
        pkt_q <= make_pkt(rdma_op_pkg::RPC_REQUEST, req_q, req_q.lvaddr, req_q.rvaddr,
                          req_q.len);
      st_parse_write_init, st_parse_write:
        if (fits_pmtu) begin
          pkt_q <= make_pkt(first_pkt ? rdma_op_pkg::WRITE_ONLY : rdma_op_pkg::WRITE_LAST,
                            req_q, lva, rva, len_rem);
          len_rem <= '0;
        end else begin
          pkt_q <= make_pkt(first_pkt ? rdma_op_pkg::WRITE_FIRST : rdma_op_pkg::WRITE_MIDDLE,
                            req_q, lva, rva, 32'(rdma_op_pkg::pmtu_bytes));
          lva     <= lva + 48'(rdma_op_pkg::pmtu_bytes);
          rva     <= rva + 48'(rdma_op_pkg::pmtu_bytes);
          len_rem <= len_rem - 32'(rdma_op_pkg::pmtu_bytes);
        end
      default: ;  // send states hold the packet
    endcase
  end

  // a stalled packet stays put until the output queue takes it
  a_pkt_stable : assert property (@(posedge aclk) disable iff (!aresetn)
    pkt_valid && !pkt_ready |=> pkt_valid && $stable(pkt_q))
    else $error("parser packet changed while stalled");

endmodule

// ==== verilog/req_arbiter.sv ====
`timescale 1ns/1ps

module req_arbiter (
  input  logic                 aclk,
  input  logic                 aresetn,
  input  req_fmt_pkg::rc_req_t a_data,
  input  logic                 a_valid,
  output logic                 a_ready,
  input  req_fmt_pkg::rc_req_t b_data,
  input  logic                 b_valid,
  output logic                 b_ready,
  output req_fmt_pkg::rc_req_t out_data,
  output logic                 out_valid,
  input  logic                 out_ready
);

  logic last_b;   // b won the last transfer
  logic locked;   // grant held while a stalled word waits
  logic grant_b;  // grant captured at stall
  logic sel_b;

  always_comb begin
    if (locked) begin
      sel_b = grant_b;
    end else if (a_valid && b_valid) begin
      sel_b = !last_b;  // favour whoever did not go last
    end else begin
      sel_b = b_valid;
    end
  end

  assign out_valid = sel_b ? b_valid : a_valid;
  assign out_data  = sel_b ? b_data : a_data;
  assign a_ready   = !sel_b && out_ready;
  assign b_ready   = sel_b && out_ready;

  always_ff @(posedge aclk, negedge aresetn) begin
    if (!aresetn) begin
      last_b  <= 1'b1;  // a goes first after reset
      locked  <= 1'b0;
      grant_b <= 1'b0;
    end else if (out_valid && out_ready) begin
      last_b <= sel_b;
      locked <= 1'b0;
    end else if (out_valid) begin
      locked  <= 1'b1;
      grant_b <= sel_b;
    end
  end

  a_grant_hold : assert property (@(posedge aclk) disable iff (!aresetn)
    out_valid && !out_ready |=> sel_b == $past(sel_b))
    else $error("arbiter grant moved during a stall");

endmodule

// ==== verilog/rdma_req_top.sv ====
`timescale 1ns/1ps

module rdma_req_top (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  req_fmt_pkg::app_req_t host_req_data,
  input  logic                  host_req_valid,
  output logic                  host_req_ready,
  input  req_fmt_pkg::app_req_t user_req_data,
  input  logic                  user_req_valid,
  output logic                  user_req_ready,
  output req_fmt_pkg::rc_req_t  req_out_data,
  output logic                  req_out_valid,
  input  logic                  req_out_ready,
  output logic [31:0]           host_used,
  output logic [31:0]           user_used
);

  req_fmt_pkg::rc_req_t host_link_data;
  logic                 host_link_valid;
  logic                 host_link_ready;
  req_fmt_pkg::rc_req_t user_link_data;
  logic                 user_link_valid;
  logic                 user_link_ready;

  // host path in region 0
  network_req_parser #(.region_id(0), .host_access(1)) inst_parser_host (
    .aclk (aclk), .aresetn (aresetn),
    .req_in_data (host_req_data), .req_in_valid (host_req_valid),
    .req_in_ready (host_req_ready),
    .req_out_data (host_link_data), .req_out_valid (host_link_valid),
    .req_out_ready (host_link_ready),
    .used (host_used)
  );

  // user logic path in region 1
  network_req_parser #(.region_id(1), .host_access(0)) inst_parser_user (
    .aclk (aclk), .aresetn (aresetn),
    .req_in_data (user_req_data), .req_in_valid (user_req_valid),
    .req_in_ready (user_req_ready),
    .req_out_data (user_link_data), .req_out_valid (user_link_valid),
    .req_out_ready (user_link_ready),
    .used (user_used)
  );

  req_arbiter inst_arbiter (
    .aclk (aclk), .aresetn (aresetn),
    .a_data (host_link_data), .a_valid (host_link_valid), .a_ready (host_link_ready),
    .b_data (user_link_data), .b_valid (user_link_valid), .b_ready (user_link_ready),
    .out_data (req_out_data), .out_valid (req_out_valid), .out_ready (req_out_ready)
  );

endmodule

// ==== bench/req_checker.sv ====
`timescale 1ns/1ps

module req_checker (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  req_fmt_pkg::app_req_t host_req_data,
  input  logic                  host_req_valid,
  input  logic                  host_req_ready,
  input  req_fmt_pkg::app_req_t user_req_data,
  input  logic                  user_req_valid,
  input  logic                  user_req_ready,
  input  req_fmt_pkg::rc_req_t  out_data,
  input  logic                  out_valid,
  input  logic                  out_ready,
  output logic [31:0]           errors,
  output logic [31:0]           pending,
  output logic [31:0]           matched
);

  req_fmt_pkg::rc_req_t host_q[$];  // expected words for region 0
  req_fmt_pkg::rc_req_t user_q[$];  // expected words for region 1

  // expected RC words for one accepted application request
  function automatic void expand_req(input req_fmt_pkg::app_req_t r, input bit from_user);
    req_fmt_pkg::rc_req_t w;
    logic [31:0]          rem;
    logic [47:0]          off;
    bit                   first;
    bit                   done;
    w.op = r.op;
    w.qp = r.qp;
    w.region = from_user ? 4'd1 : 4'd0;
    w.host = !from_user;
    w.rsrvd = '0;
    w.lvaddr = r.lvaddr;
    w.rvaddr = r.rvaddr;
    w.len = r.len;
    w.params = r.params;
    if (!r.raw) begin
      case (r.op)
        req_fmt_pkg::APP_READ: w.op = rdma_op_pkg::READ_REQUEST;
        req_fmt_pkg::APP_RPC:  w.op = rdma_op_pkg::RPC_REQUEST;
        req_fmt_pkg::APP_WRITE: begin
          rem = r.len;
          off = '0;
          first = 1'b1;
          done = 1'b0;
          while (!done) begin  // one packet per pmtu chunk
            w.lvaddr = r.lvaddr + off;
            w.rvaddr = r.rvaddr + off;
            if (rem <= 32'(rdma_op_pkg::pmtu_bytes)) begin
              w.op = first ? rdma_op_pkg::WRITE_ONLY : rdma_op_pkg::WRITE_LAST;
              w.len = rem;
              done = 1'b1;
            end else begin
              w.op = first ? rdma_op_pkg::WRITE_FIRST : rdma_op_pkg::WRITE_MIDDLE;
              w.len = 32'(rdma_op_pkg::pmtu_bytes);
              rem = rem - 32'(rdma_op_pkg::pmtu_bytes);
              off = off + 48'(rdma_op_pkg::pmtu_bytes);
            end
            if (from_user) user_q.push_back(w);
            else host_q.push_back(w);
            first = 1'b0;
          end
          return;
        end
        default: return;  // unknown parsed opcode gives nothing
      endcase
    end
    if (from_user) user_q.push_back(w);
    else host_q.push_back(w);
  endfunction

  function automatic void compare_out(input req_fmt_pkg::rc_req_t got);
    req_fmt_pkg::rc_req_t exp;
    if (got.region > 4'd1) begin
      $display("[FAIL] %0t output with unknown region %0d", $time, got.region);
      errors = errors + 1;
    end else if ((got.region == 4'd0 && host_q.size() == 0) ||
                 (got.region == 4'd1 && user_q.size() == 0)) begin
      $display("[FAIL] %0t unexpected output in region %0d op %0d", $time, got.region, got.op);
      errors = errors + 1;
    end else begin
      if (got.region == 4'd0) exp = host_q.pop_front();
      else exp = user_q.pop_front();
      if (got !== exp) begin
        $display("[FAIL] %0t region %0d got op %0d len %0d lva %h rva %h host %b rsrvd %h",
                 $time, got.region, got.op, got.len, got.lvaddr, got.rvaddr, got.host,
                 got.rsrvd);
        $display("       expected op %0d len %0d lva %h rva %h host %b qp %h/%h", exp.op,
                 exp.len, exp.lvaddr, exp.rvaddr, exp.host, exp.qp, got.qp);
        errors = errors + 1;
      end else begin
        matched = matched + 1;
      end
    end
  endfunction

  // sampled mid-cycle so transfers complete on the next rising edge
  always @(negedge aclk) begin
    if (!aresetn) begin
      host_q.delete();
      user_q.delete();
      errors = '0;
      matched = '0;
      pending = '0;
    end else begin
      if (host_req_valid && host_req_ready) expand_req(host_req_data, 1'b0);
      if (user_req_valid && user_req_ready) expand_req(user_req_data, 1'b1);
      if (out_valid && out_ready) compare_out(out_data);
      pending = 32'(host_q.size() + user_q.size());
    end
  end

endmodule

// ==== bench/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

  localparam int queue_depth = 16;     // parser input queue
  localparam int ready_limit = 5000;   // cycles a source may wait for ready
  localparam int drain_limit = 20000;

  logic                  aclk;
  logic                  aresetn;
  req_fmt_pkg::app_req_t host_req_data;
  logic                  host_req_valid;
  logic                  host_req_ready;
  req_fmt_pkg::app_req_t user_req_data;
  logic                  user_req_valid;
  logic                  user_req_ready;
  req_fmt_pkg::rc_req_t  req_out_data;
  logic                  req_out_valid;
  logic                  req_out_ready;
  logic [31:0]           host_used;
  logic [31:0]           user_used;
  logic [31:0]           chk_errors;
  logic [31:0]           chk_pending;
  logic [31:0]           chk_matched;
  int                    bp_mode = 0;  // 0 ready, 1 stalled, 2 random
  bit                    timed_out = 1'b0;
  int                    tb_errors = 0;
  int                    err_mark = 0;
  int                    tests_run = 0;
  int                    tests_ok = 0;

  rdma_req_top dut_i (
    .aclk (aclk), .aresetn (aresetn),
    .host_req_data (host_req_data), .host_req_valid (host_req_valid),
    .host_req_ready (host_req_ready),
    .user_req_data (user_req_data), .user_req_valid (user_req_valid),
    .user_req_ready (user_req_ready),
    .req_out_data (req_out_data), .req_out_valid (req_out_valid),
    .req_out_ready (req_out_ready),
    .host_used (host_used), .user_used (user_used)
  );

  req_checker chk_i (
    .aclk (aclk), .aresetn (aresetn),
    .host_req_data (host_req_data), .host_req_valid (host_req_valid),
    .host_req_ready (host_req_ready),
    .user_req_data (user_req_data), .user_req_valid (user_req_valid),
    .user_req_ready (user_req_ready),
    .out_data (req_out_data), .out_valid (req_out_valid), .out_ready (req_out_ready),
    .errors (chk_errors), .pending (chk_pending), .matched (chk_matched)
  );

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  initial begin
    req_out_ready = 1'b1;
    forever begin
      @(posedge aclk);
      #1;
      case (bp_mode)
        1:       req_out_ready = 1'b0;
        2:       req_out_ready = ($urandom % 4) != 0;  // ready 3 cycles in 4
        default: req_out_ready = 1'b1;
      endcase
    end
  end

  function automatic req_fmt_pkg::app_req_t build_req(input logic [4:0] op, input logic raw,
                                                      input logic [31:0] len);
    req_fmt_pkg::app_req_t r;
    r.op = op;
    r.qp = 24'($urandom);
    r.region = 4'($urandom);  // junk that the stamp replaces
    r.host = 1'($urandom);
    r.raw = raw;
    r.rsrvd = 29'($urandom);
    r.lvaddr = {16'($urandom), $urandom};
    r.rvaddr = {16'($urandom), $urandom};
    r.len = len;
    r.params = {$urandom, $urandom};
    return r;
  endfunction

  function automatic req_fmt_pkg::app_req_t random_req();
    logic [31:0] kind;
    kind = $urandom % 4;
    case (kind)
      0: return build_req(req_fmt_pkg::APP_READ, 1'b0, $urandom % 65536);
      1: return build_req(req_fmt_pkg::APP_WRITE, 1'b0,
                          $urandom % (3 * rdma_op_pkg::pmtu_bytes + 100));
      2: return build_req(req_fmt_pkg::APP_RPC, 1'b0, $urandom % 256);
      default: return build_req(5'($urandom), 1'b1, $urandom);
    endcase
  endfunction

  // called and returns just after a rising edge
  task automatic send_req(input bit to_user, input req_fmt_pkg::app_req_t r);
    int   waited;
    logic ready_seen;
    if (timed_out) return;
    if (to_user) begin
      user_req_data = r;
      user_req_valid = 1'b1;
    end else begin
      host_req_data = r;
      host_req_valid = 1'b1;
    end
    waited = 0;
    ready_seen = 1'b0;
    while (!ready_seen && waited < ready_limit) begin
      @(negedge aclk);
      ready_seen = to_user ? user_req_ready : host_req_ready;
      waited++;
    end
    @(posedge aclk);
    #1;
    if (to_user) user_req_valid = 1'b0;
    else host_req_valid = 1'b0;
    if (!ready_seen) begin
      $display("timeout: %s input never became ready", to_user ? "user" : "host");
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_drain();
    int waited;
    if (timed_out) return;
    waited = 0;
    @(posedge aclk);
    while (chk_pending != 0 && waited < drain_limit) begin
      @(posedge aclk);
      waited++;
    end
    #1;
    if (chk_pending != 0) begin
      $display("timeout: %0d expected words never reached the output", chk_pending);
      timed_out = 1'b1;
    end
  endtask

  // releases the stall once both input queues are full
  task automatic watch_fill();
    int waited;
    waited = 0;
    while (!(host_used == queue_depth && user_used == queue_depth) && waited < ready_limit) begin
      @(negedge aclk);
      waited++;
    end
    if (host_used != queue_depth || user_used != queue_depth) begin
      $display("input queues never filled, host %0d user %0d", host_used, user_used);
      tb_errors++;
    end
    bp_mode = 2;
  endtask

  task automatic end_test(input string name);
    int errs;
    wait_drain();
    errs = int'(chk_errors) + tb_errors - err_mark;
    tests_run++;
    if (errs == 0 && !timed_out) tests_ok++;
    $display("test %0d %s: %s, %0d errors, %0d words matched", tests_run, name,
             (errs == 0 && !timed_out) ? "ok" : "bad", errs, chk_matched);
    err_mark = int'(chk_errors) + tb_errors;
  endtask

  initial begin
    logic [31:0] wr_lens [4];
    void'($urandom(96670));
    aresetn = 1'b0;
    host_req_data = '0;
    host_req_valid = 1'b0;
    user_req_data = '0;
    user_req_valid = 1'b0;
    wr_lens = '{32'd0, 32'(rdma_op_pkg::pmtu_bytes), 32'(rdma_op_pkg::pmtu_bytes + 1),
                32'(rdma_op_pkg::pmtu_bytes * 7 / 2)};
    repeat (5) @(posedge aclk);
    #1;
    aresetn = 1'b1;
    @(posedge aclk);
    #1;

    send_req(1'b0, build_req(req_fmt_pkg::APP_READ, 1'b0, 32'd512));
    send_req(1'b0, build_req(req_fmt_pkg::APP_RPC, 1'b0, 32'd64));
    send_req(1'b1, build_req(req_fmt_pkg::APP_READ, 1'b0, 32'd8192));
    send_req(1'b1, build_req(req_fmt_pkg::APP_RPC, 1'b0, 32'd0));
    end_test("read and rpc");

    for (int i = 0; i < 4; i++) begin
      send_req(1'b0, build_req(req_fmt_pkg::APP_WRITE, 1'b0, wr_lens[i]));
      send_req(1'b1, build_req(req_fmt_pkg::APP_WRITE, 1'b0, wr_lens[i]));
    end
    end_test("write split");

    for (int i = 0; i < 6; i++) begin
      send_req(1'b0, build_req(5'($urandom), 1'b1, $urandom));
      send_req(1'b1, build_req(5'($urandom), 1'b1, $urandom));
    end
    send_req(1'b0, build_req(5'd7, 1'b0, 32'd100));  // unknown opcode must vanish
    send_req(1'b0, build_req(5'd3, 1'b1, 32'd100));  // raw marker behind it
    send_req(1'b1, build_req(5'd31, 1'b0, 32'd100));
    send_req(1'b1, build_req(5'd9, 1'b1, 32'd100));
    end_test("raw and unknown");

    fork
      for (int k = 0; k < 40; k++) send_req(1'b0, random_req());
      for (int k = 0; k < 40; k++) send_req(1'b1, random_req());
    join
    end_test("random both sources");

    bp_mode = 1;
    fork
      for (int k = 0; k < 24; k++) send_req(1'b0, random_req());
      for (int k = 0; k < 24; k++) send_req(1'b1, random_req());
      watch_fill();
    join
    wait_drain();
    @(negedge aclk);
    if (host_used != 0 || user_used != 0) begin
      $display("input queues not empty after drain, host %0d user %0d", host_used, user_used);
      tb_errors++;
    end
    bp_mode = 0;
    end_test("back-pressure");

    $display("summary: %0d of %0d tests ok, %0d checker errors, %0d other errors",
             tests_ok, tests_run, chk_errors, tb_errors);
    if (tests_ok == tests_run && !timed_out && chk_errors == 0 && tb_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
verilog/rdma_op_pkg.sv
verilog/req_fmt_pkg.sv
verilog/req_fifo.sv
verilog/network_req_parser.sv
verilog/req_arbiter.sv
verilog/rdma_req_top.sv
bench/req_checker.sv
bench/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the request subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_top \
  -Mdir obj_dir -o tb_top_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_top_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
  exit 0
fi
echo "pass message not found"
exit 1
